// File: include/rename_params.svh
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Lane count of the rename group
`define RN_LANES 3

// Instruction and PC width
`define RN_XLEN 32

// Register file sizes
`define RN_ARCH_REGS 32
`define RN_PHYS_REGS 64

// Tag widths
`define RN_ARCH_W 5
`define RN_PHYS_W 6

// Free list holds the physical registers not mapped at reset
`define RN_FREE_DEPTH 32
`define RN_CNT_W 6

`endif

// File: verilog/rename_pkg.sv
`include "rename_params.svh"

package rename_pkg;

    typedef logic [`RN_ARCH_W-1:0] arch_reg_t;   // Architectural index
    typedef logic [`RN_PHYS_W-1:0] phys_reg_t;   // Physical tag

    // ====================
    // RV32I major opcodes
    // ====================
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // Register view, also covers I/U/J for the rd field
    typedef struct packed {
        logic [6:0] funct7;
        arch_reg_t  rs2;
        arch_reg_t  rs1;
        logic [2:0] funct3;
        arch_reg_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Store and branch view, bits 11:7 are immediate here
    typedef struct packed {
        logic [6:0] imm_hi;
        arch_reg_t  rs2;
        arch_reg_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r;
        s_fmt_t s;
    } instr_u;

endpackage

// File: verilog/reg_field_decoder.sv
`timescale 1ns/1ps
`include "rename_params.svh"

module reg_field_decoder (
    input  rename_pkg::instr_u    instr_i,
    output rename_pkg::arch_reg_t rs1_o,
    output rename_pkg::arch_reg_t rs2_o,
    output rename_pkg::arch_reg_t rd_o,
    output logic                  rd_we_o
);

    rename_pkg::opcode_e opc;
    logic                use_rs1;
    logic                use_rs2;
    logic                has_rd;

    assign opc = rename_pkg::opcode_e'(instr_i.r.opcode);

    // Operand usage per format
    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        has_rd  = 1'b0;
        case (opc)
            rename_pkg::OPC_LUI, rename_pkg::OPC_AUIPC, rename_pkg::OPC_JAL: begin
                has_rd = 1'b1;             // No register sources
            end
            rename_pkg::OPC_JALR, rename_pkg::OPC_LOAD, rename_pkg::OPC_OP_IMM: begin
                use_rs1 = 1'b1;
                has_rd  = 1'b1;
            end
            rename_pkg::OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                has_rd  = 1'b1;
            end
            rename_pkg::OPC_STORE, rename_pkg::OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Sources sit at the same bits in every format
    assign rs1_o = use_rs1 ? instr_i.r.rs1 : '0;
    assign rs2_o = use_rs2 ? instr_i.r.rs2 : '0;

    // Bits 11:7 only count as rd in a writing format
    assign rd_o    = has_rd ? instr_i.r.rd : '0;
    assign rd_we_o = has_rd && (instr_i.r.rd != '0);

    // Idle lanes may carry an all-zero word or be undriven
    a_known_opcode: assert final ($isunknown(instr_i) || (instr_i == '0) ||
                                  (instr_i.r.opcode inside {rename_pkg::OPC_LUI,
                                   rename_pkg::OPC_AUIPC, rename_pkg::OPC_JAL,
                                   rename_pkg::OPC_JALR, rename_pkg::OPC_BRANCH,
                                   rename_pkg::OPC_LOAD, rename_pkg::OPC_STORE,
                                   rename_pkg::OPC_OP_IMM, rename_pkg::OPC_OP}))
        else $error("unknown opcode %b", instr_i.r.opcode);

endmodule

// File: verilog/rename_map.sv
`timescale 1ns/1ps
`include "rename_params.svh"

module rename_map (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  accept_i      [`RN_LANES],
    input  rename_pkg::arch_reg_t rs1_i         [`RN_LANES],
    input  rename_pkg::arch_reg_t rs2_i         [`RN_LANES],
    input  rename_pkg::arch_reg_t rd_i          [`RN_LANES],
    input  logic                  rd_we_i       [`RN_LANES],
    input  rename_pkg::phys_reg_t new_tag_i     [`RN_LANES],
    output rename_pkg::phys_reg_t rs1_phys_o    [`RN_LANES],
    output rename_pkg::phys_reg_t rs2_phys_o    [`RN_LANES],
    output rename_pkg::phys_reg_t old_rd_phys_o [`RN_LANES]
);

    rename_pkg::phys_reg_t map_q [`RN_ARCH_REGS];   // Arch to phys mapping
    logic                  lane_wr [`RN_LANES];      // Accepted and writing

    always_comb begin
        for (int l = 0; l < `RN_LANES; l++) begin
            lane_wr[l] = accept_i[l] && rd_we_i[l];
        end
    end

    // ====================
    // Lookup with intra-group bypass
    // ====================
    // Inner loop runs oldest to newest, so the newest earlier writer wins
    always_comb begin
        for (int l = 0; l < `RN_LANES; l++) begin
            rs1_phys_o[l]    = map_q[rs1_i[l]];
            rs2_phys_o[l]    = map_q[rs2_i[l]];
            old_rd_phys_o[l] = map_q[rd_i[l]];
            for (int p = 0; p < l; p++) begin
                if (lane_wr[p]) begin
                    if (rd_i[p] == rs1_i[l]) rs1_phys_o[l] = new_tag_i[p];
                    if (rd_i[p] == rs2_i[l]) rs2_phys_o[l] = new_tag_i[p];
                    if (rd_i[p] == rd_i[l])  old_rd_phys_o[l] = new_tag_i[p];
                end
            end
        end
    end

    // ====================
    // Map update
    // ====================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phys_reg_t'(i);   // Identity mapping
            end
        end else begin
            // Later lanes overwrite earlier ones on the same rd
            for (int l = 0; l < `RN_LANES; l++) begin
                if (lane_wr[l] && (rd_i[l] != '0)) begin
                    map_q[rd_i[l]] <= new_tag_i[l];
                end
            end
        end
    end

    // Decoder must never flag x0 as a destination
    for (genvar g = 0; g < `RN_LANES; g++) begin : g_x0_chk
        a_no_x0_write: assert property (@(posedge clk) disable iff (!reset)
            lane_wr[g] |-> (rd_i[g] != '0))
            else $error("lane %0d renames x0", g);
    end

endmodule

// File: verilog/phys_reg_allocator.sv
`timescale 1ns/1ps
`include "rename_params.svh"

module phys_reg_allocator (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dispatch_ready_i [`RN_LANES],
    input  logic                  decode_valid_i   [`RN_LANES],
    input  logic                  rd_we_i          [`RN_LANES],
    input  logic                  commit_valid_i   [`RN_LANES],
    input  rename_pkg::phys_reg_t commit_tag_i     [`RN_LANES],
    output logic                  grant_o          [`RN_LANES],
    output rename_pkg::phys_reg_t alloc_tag_o      [`RN_LANES]
);

    localparam int PTR_W = $clog2(`RN_FREE_DEPTH);
    localparam int CNT_W = `RN_CNT_W;

    rename_pkg::phys_reg_t free_q [`RN_FREE_DEPTH];   // Circular tag buffer
    logic [PTR_W-1:0]      head_q;                    // Next tag to hand out
    logic [PTR_W-1:0]      tail_q;                    // Next slot for a commit
    logic [CNT_W-1:0]      count_q;                   // Free tags held

    logic [CNT_W-1:0]      grant_n;
    logic [CNT_W-1:0]      pop_n;
    logic [CNT_W-1:0]      push_n;
    logic [PTR_W-1:0]      wr_ptr [`RN_LANES];

    // ====================
    // Lane grant
    // ====================
    // First ready lanes in lane order, no more than the free tags on hand
    always_comb begin
        grant_n = '0;
        for (int l = 0; l < `RN_LANES; l++) begin
            grant_o[l] = 1'b0;
            if (dispatch_ready_i[l] && (grant_n < count_q)) begin
                grant_o[l] = 1'b1;
                grant_n    = grant_n + 1'b1;
            end
        end
    end

    // Consecutive head entries go to accepted writing lanes
    always_comb begin
        pop_n = '0;
        for (int l = 0; l < `RN_LANES; l++) begin
            alloc_tag_o[l] = free_q[PTR_W'(head_q + pop_n)];
            if (grant_o[l] && decode_valid_i[l] && rd_we_i[l]) begin
                pop_n = pop_n + 1'b1;
            end
        end
    end

    // Commit slots at the tail, in lane order
    always_comb begin
        push_n = '0;
        for (int l = 0; l < `RN_LANES; l++) begin
            wr_ptr[l] = PTR_W'(tail_q + push_n);
            if (commit_valid_i[l]) begin
                push_n = push_n + 1'b1;
            end
        end
    end

    // ====================
    // FIFO state
    // ====================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
                free_q[i] <= rename_pkg::phys_reg_t'(`RN_ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;                            // Full, tail meets head
            count_q <= CNT_W'(`RN_FREE_DEPTH);
        end else begin
            for (int l = 0; l < `RN_LANES; l++) begin
                if (commit_valid_i[l]) begin
                    free_q[wr_ptr[l]] <= commit_tag_i[l];
                end
            end
            head_q  <= PTR_W'(head_q + pop_n);
            tail_q  <= PTR_W'(tail_q + push_n);
            count_q <= count_q - pop_n + push_n;
        end
    end

    // Commits beyond outstanding tags would overfill the list
    a_count_bound: assert property (@(posedge clk) disable iff (!reset)
        count_q <= `RN_FREE_DEPTH)
        else $error("free list count %0d above capacity", count_q);

    for (genvar g = 0; g < `RN_LANES; g++) begin : g_push_chk
        a_push_nonzero: assert property (@(posedge clk) disable iff (!reset)
            commit_valid_i[g] |-> (commit_tag_i[g] != '0))
            else $error("lane %0d commits tag 0", g);
    end

endmodule

// File: verilog/issue_pipe_reg.sv
`timescale 1ns/1ps
`include "rename_params.svh"

module issue_pipe_reg (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dispatch_ready_i [`RN_LANES],
    input  logic                  accept_i         [`RN_LANES],
    input  logic [`RN_XLEN-1:0]   pc_i             [`RN_LANES],
    input  rename_pkg::phys_reg_t rs1_phys_i       [`RN_LANES],
    input  rename_pkg::phys_reg_t rs2_phys_i       [`RN_LANES],
    input  rename_pkg::phys_reg_t rd_phys_i        [`RN_LANES],
    input  rename_pkg::phys_reg_t old_rd_phys_i    [`RN_LANES],
    input  rename_pkg::arch_reg_t rd_arch_i        [`RN_LANES],
    input  logic                  rd_we_i          [`RN_LANES],
    output logic                  issue_valid_o    [`RN_LANES],
    output logic [`RN_XLEN-1:0]   pc_o             [`RN_LANES],
    output rename_pkg::phys_reg_t rs1_phys_o       [`RN_LANES],
    output rename_pkg::phys_reg_t rs2_phys_o       [`RN_LANES],
    output rename_pkg::phys_reg_t rd_phys_o        [`RN_LANES],
    output rename_pkg::phys_reg_t old_rd_phys_o    [`RN_LANES],
    output rename_pkg::arch_reg_t rd_arch_o        [`RN_LANES],
    output logic                  rd_we_o          [`RN_LANES]
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int l = 0; l < `RN_LANES; l++) begin
                issue_valid_o[l] <= 1'b0;
                pc_o[l]          <= '0;
                rs1_phys_o[l]    <= '0;
                rs2_phys_o[l]    <= '0;
                rd_phys_o[l]     <= '0;
                old_rd_phys_o[l] <= '0;
                rd_arch_o[l]     <= '0;
                rd_we_o[l]       <= 1'b0;
            end
        end else begin
            for (int l = 0; l < `RN_LANES; l++) begin
                issue_valid_o[l] <= accept_i[l];    // Drops on stall or bubble
                // Fields hold while dispatch stalls this lane
                if (dispatch_ready_i[l]) begin
                    pc_o[l]          <= accept_i[l] ? pc_i[l]          : '0;
                    rs1_phys_o[l]    <= accept_i[l] ? rs1_phys_i[l]    : '0;
                    rs2_phys_o[l]    <= accept_i[l] ? rs2_phys_i[l]    : '0;
                    rd_phys_o[l]     <= accept_i[l] ? rd_phys_i[l]     : '0;
                    old_rd_phys_o[l] <= accept_i[l] ? old_rd_phys_i[l] : '0;
                    rd_arch_o[l]     <= accept_i[l] ? rd_arch_i[l]     : '0;
                    rd_we_o[l]       <= accept_i[l] && rd_we_i[l];
                end
            end
        end
    end

    // Grant logic must never accept into a stalled lane
    for (genvar g = 0; g < `RN_LANES; g++) begin : g_accept_chk
        a_accept_ready: assert property (@(posedge clk) disable iff (!reset)
            accept_i[g] |-> dispatch_ready_i[g])
            else $error("lane %0d accepted while dispatch stalled", g);
    end

endmodule

// File: verilog/rename_stage.sv
`timescale 1ns/1ps
`include "rename_params.svh"

module rename_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  decode_valid_i   [`RN_LANES],
    input  logic [`RN_XLEN-1:0]   instr_i          [`RN_LANES],
    input  logic [`RN_XLEN-1:0]   pc_i             [`RN_LANES],
    input  logic                  dispatch_ready_i [`RN_LANES],
    input  logic                  commit_valid_i   [`RN_LANES],
    input  rename_pkg::phys_reg_t commit_tag_i     [`RN_LANES],
    output logic                  decode_ready_o   [`RN_LANES],
    output logic                  issue_valid_o    [`RN_LANES],
    output logic [`RN_XLEN-1:0]   pc_o             [`RN_LANES],
    output rename_pkg::phys_reg_t rs1_phys_o       [`RN_LANES],
    output rename_pkg::phys_reg_t rs2_phys_o       [`RN_LANES],
    output rename_pkg::phys_reg_t rd_phys_o        [`RN_LANES],
    output rename_pkg::phys_reg_t old_rd_phys_o    [`RN_LANES],
    output rename_pkg::arch_reg_t rd_arch_o        [`RN_LANES],
    output logic                  rd_we_o          [`RN_LANES]
);

    rename_pkg::arch_reg_t dec_rs1   [`RN_LANES];
    rename_pkg::arch_reg_t dec_rs2   [`RN_LANES];
    rename_pkg::arch_reg_t dec_rd    [`RN_LANES];
    logic                  dec_we    [`RN_LANES];
    logic                  grant     [`RN_LANES];
    logic                  accept    [`RN_LANES];   // Handshake taken this edge
    rename_pkg::phys_reg_t alloc_tag [`RN_LANES];
    rename_pkg::phys_reg_t rd_phys   [`RN_LANES];
    rename_pkg::phys_reg_t rs1_phys  [`RN_LANES];
    rename_pkg::phys_reg_t rs2_phys  [`RN_LANES];
    rename_pkg::phys_reg_t old_phys  [`RN_LANES];

    // ====================
    // Per-lane decode
    // ====================
    for (genvar g = 0; g < `RN_LANES; g++) begin : g_lane
        reg_field_decoder u_dec (
            .instr_i (instr_i[g]),
            .rs1_o   (dec_rs1[g]),
            .rs2_o   (dec_rs2[g]),
            .rd_o    (dec_rd[g]),
            .rd_we_o (dec_we[g])
        );

        assign accept[g]         = grant[g] && decode_valid_i[g];
        assign decode_ready_o[g] = grant[g];
        assign rd_phys[g]        = dec_we[g] ? alloc_tag[g] : '0;   // No tag for non-writers
    end

    phys_reg_allocator u_alloc (
        .clk              (clk),
        .reset            (reset),
        .dispatch_ready_i (dispatch_ready_i),
        .decode_valid_i   (decode_valid_i),
        .rd_we_i          (dec_we),
        .commit_valid_i   (commit_valid_i),
        .commit_tag_i     (commit_tag_i),
        .grant_o          (grant),
        .alloc_tag_o      (alloc_tag)
    );

    rename_map u_map (
        .clk           (clk),
        .reset         (reset),
        .accept_i      (accept),
        .rs1_i         (dec_rs1),
        .rs2_i         (dec_rs2),
        .rd_i          (dec_rd),
        .rd_we_i       (dec_we),
        .new_tag_i     (alloc_tag),
        .rs1_phys_o    (rs1_phys),
        .rs2_phys_o    (rs2_phys),
        .old_rd_phys_o (old_phys)
    );

    // Registered hand-off toward dispatch
    issue_pipe_reg u_pipe (
        .clk              (clk),
        .reset            (reset),
        .dispatch_ready_i (dispatch_ready_i),
        .accept_i         (accept),
        .pc_i             (pc_i),
        .rs1_phys_i       (rs1_phys),
        .rs2_phys_i       (rs2_phys),
        .rd_phys_i        (rd_phys),
        .old_rd_phys_i    (old_phys),
        .rd_arch_i        (dec_rd),
        .rd_we_i          (dec_we),
        .issue_valid_o    (issue_valid_o),
        .pc_o             (pc_o),
        .rs1_phys_o       (rs1_phys_o),
        .rs2_phys_o       (rs2_phys_o),
        .rd_phys_o        (rd_phys_o),
        .old_rd_phys_o    (old_rd_phys_o),
        .rd_arch_o        (rd_arch_o),
        .rd_we_o          (rd_we_o)
    );

endmodule

// File: sim/rename_tb_model.svh
`ifndef RENAME_TB_MODEL_SVH
`define RENAME_TB_MODEL_SVH

`include "rename_params.svh"

// ====================
// Reference state
// ====================
rename_pkg::phys_reg_t map_m    [`RN_ARCH_REGS];   // Arch to phys mapping
rename_pkg::phys_reg_t free_m   [$];               // Free tags, head at the front
rename_pkg::phys_reg_t retire_q [$];               // Old tags not yet committed

// Expected DUT outputs
logic                  exp_ready   [`RN_LANES];
logic                  exp_valid   [`RN_LANES];
logic [`RN_XLEN-1:0]   exp_pc      [`RN_LANES];
rename_pkg::phys_reg_t exp_rs1     [`RN_LANES];
rename_pkg::phys_reg_t exp_rs2     [`RN_LANES];
rename_pkg::phys_reg_t exp_rd_phys [`RN_LANES];
rename_pkg::phys_reg_t exp_old     [`RN_LANES];
rename_pkg::arch_reg_t exp_rd_arch [`RN_LANES];
logic                  exp_we      [`RN_LANES];

function automatic void model_reset();
    for (int i = 0; i < `RN_ARCH_REGS; i++) begin
        map_m[i] = rename_pkg::phys_reg_t'(i);
    end
    free_m.delete();
    retire_q.delete();
    for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
        free_m.push_back(rename_pkg::phys_reg_t'(`RN_ARCH_REGS + i));
    end
    for (int l = 0; l < `RN_LANES; l++) begin
        exp_ready[l]   = 1'b0;
        exp_valid[l]   = 1'b0;
        exp_pc[l]      = '0;
        exp_rs1[l]     = '0;
        exp_rs2[l]     = '0;
        exp_rd_phys[l] = '0;
        exp_old[l]     = '0;
        exp_rd_arch[l] = '0;
        exp_we[l]      = 1'b0;
    end
endfunction

// Register fields per RV32I format, unused fields read as x0
function automatic void decode_fields(input logic [31:0] w,
                                      output rename_pkg::arch_reg_t rs1,
                                      output rename_pkg::arch_reg_t rs2,
                                      output rename_pkg::arch_reg_t rd,
                                      output logic we);
    logic use1;
    logic use2;
    logic has_rd;
    use1   = 1'b0;
    use2   = 1'b0;
    has_rd = 1'b0;
    case (w[6:0])
        rename_pkg::OPC_LUI, rename_pkg::OPC_AUIPC, rename_pkg::OPC_JAL: has_rd = 1'b1;
        rename_pkg::OPC_JALR, rename_pkg::OPC_LOAD, rename_pkg::OPC_OP_IMM: begin
            use1   = 1'b1;
            has_rd = 1'b1;
        end
        rename_pkg::OPC_OP: begin
            use1   = 1'b1;
            use2   = 1'b1;
            has_rd = 1'b1;
        end
        rename_pkg::OPC_STORE, rename_pkg::OPC_BRANCH: begin
            use1 = 1'b1;
            use2 = 1'b1;
        end
        default: begin
        end
    endcase
    rs1 = use1 ? w[19:15] : '0;
    rs2 = use2 ? w[24:20] : '0;
    rd  = has_rd ? w[11:7] : '0;
    we  = has_rd && (w[11:7] != '0);
endfunction

// One clock edge: grant, allocation, rename, output registers, commit
function automatic void model_step();
    int                    n_free;
    int                    n_grant;
    logic                  acc;
    logic                  we;
    rename_pkg::arch_reg_t rs1;
    rename_pkg::arch_reg_t rs2;
    rename_pkg::arch_reg_t rd;
    rename_pkg::phys_reg_t tag;
    rename_pkg::phys_reg_t p1;
    rename_pkg::phys_reg_t p2;
    rename_pkg::phys_reg_t po;
    n_free  = free_m.size();                    // Count at the start of the cycle
    n_grant = 0;
    for (int l = 0; l < `RN_LANES; l++) begin
        exp_ready[l] = dispatch_ready[l] && (n_grant < n_free);
        if (exp_ready[l]) n_grant++;
        acc = exp_ready[l] && decode_valid[l];
        decode_fields(instr[l], rs1, rs2, rd, we);
        tag = '0;
        p1  = map_m[rs1];
        p2  = map_m[rs2];
        po  = map_m[rd];
        if (acc && we) begin
            tag       = free_m.pop_front();
            map_m[rd] = tag;                    // Later lanes of the group see it
            retire_q.push_back(po);
        end
        exp_valid[l] = acc;
        if (dispatch_ready[l]) begin
            exp_pc[l]      = acc ? pc_in[l] : '0;
            exp_rs1[l]     = acc ? p1 : '0;
            exp_rs2[l]     = acc ? p2 : '0;
            exp_rd_phys[l] = tag;
            exp_old[l]     = acc ? po : '0;
            exp_rd_arch[l] = acc ? rd : '0;
            exp_we[l]      = acc && we;
        end
    end
    // Commits go in behind the pops
    for (int l = 0; l < `RN_LANES; l++) begin
        if (commit_valid[l]) free_m.push_back(commit_tag[l]);
    end
endfunction

`endif

// File: sim/rename_tb.sv
`timescale 1ns/1ps
`include "rename_params.svh"

module rename_tb;

    localparam int RESET_CYCLES    = 8;
    localparam int DIRECTED_CYCLES = 52;     // Directed groups and drain, rounded up
    localparam int RANDOM_GROUPS   = 340;
    localparam int TIMEOUT_CYCLES  = 5 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_GROUPS);

    localparam logic [6:0] LUI    = rename_pkg::OPC_LUI;
    localparam logic [6:0] AUIPC  = rename_pkg::OPC_AUIPC;
    localparam logic [6:0] JAL    = rename_pkg::OPC_JAL;
    localparam logic [6:0] JALR   = rename_pkg::OPC_JALR;
    localparam logic [6:0] BRANCH = rename_pkg::OPC_BRANCH;
    localparam logic [6:0] LOAD   = rename_pkg::OPC_LOAD;
    localparam logic [6:0] STORE  = rename_pkg::OPC_STORE;
    localparam logic [6:0] OP_IMM = rename_pkg::OPC_OP_IMM;
    localparam logic [6:0] OP     = rename_pkg::OPC_OP;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  decode_valid   [`RN_LANES];
    logic [`RN_XLEN-1:0]   instr          [`RN_LANES];
    logic [`RN_XLEN-1:0]   pc_in          [`RN_LANES];
    logic                  dispatch_ready [`RN_LANES];
    logic                  commit_valid   [`RN_LANES];
    rename_pkg::phys_reg_t commit_tag     [`RN_LANES];
    logic                  decode_ready   [`RN_LANES];
    logic                  issue_valid    [`RN_LANES];
    logic [`RN_XLEN-1:0]   pc_out         [`RN_LANES];
    rename_pkg::phys_reg_t rs1_phys       [`RN_LANES];
    rename_pkg::phys_reg_t rs2_phys       [`RN_LANES];
    rename_pkg::phys_reg_t rd_phys        [`RN_LANES];
    rename_pkg::phys_reg_t old_rd_phys    [`RN_LANES];
    rename_pkg::arch_reg_t rd_arch        [`RN_LANES];
    logic                  rd_we          [`RN_LANES];

    string                 test_name = "reset";
    int                    err_cnt   = 0;
    int                    cycle_cnt = 0;
    logic [`RN_XLEN-1:0]   pc_next   = 32'h0000_1000;

    `include "rename_tb_model.svh"

    rename_stage dut (
        .clk              (clk),
        .reset            (reset),
        .decode_valid_i   (decode_valid),
        .instr_i          (instr),
        .pc_i             (pc_in),
        .dispatch_ready_i (dispatch_ready),
        .commit_valid_i   (commit_valid),
        .commit_tag_i     (commit_tag),
        .decode_ready_o   (decode_ready),
        .issue_valid_o    (issue_valid),
        .pc_o             (pc_out),
        .rs1_phys_o       (rs1_phys),
        .rs2_phys_o       (rs2_phys),
        .rd_phys_o        (rd_phys),
        .old_rd_phys_o    (old_rd_phys),
        .rd_arch_o        (rd_arch),
        .rd_we_o          (rd_we)
    );

    always #10 clk = ~clk;

    // Register-view encoding, bits 11:7 are the immediate for stores and branches
    function automatic logic [31:0] enc(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'h00, rs2, rs1, 3'b000, rd, opc};
    endfunction

    function automatic logic [31:0] rand_instr();
        logic [6:0]  opc;
        logic [24:0] body;
        case ($urandom_range(8))
            0: opc = LUI;
            1: opc = AUIPC;
            2: opc = JAL;
            3: opc = JALR;
            4: opc = BRANCH;
            5: opc = LOAD;
            6: opc = STORE;
            7: opc = OP_IMM;
            default: opc = OP;
        endcase
        body = 25'($urandom());
        return {body, opc};
    endfunction

    function automatic logic [31:0] rand_writer();
        return enc(OP, 5'(1 + $urandom_range(30)), 5'($urandom()), 5'($urandom()));
    endfunction

    task automatic drive_idle();
        for (int l = 0; l < `RN_LANES; l++) begin
            decode_valid[l]   = 1'b0;
            instr[l]          = '0;
            pc_in[l]          = '0;
            dispatch_ready[l] = 1'b0;
            commit_valid[l]   = 1'b0;
            commit_tag[l]     = '0;
        end
    endtask

    // One group on the falling edge, commits taken from the old tags handed out
    task automatic step_group(input logic [31:0] w0, input logic [31:0] w1,
                              input logic [31:0] w2, input logic [2:0] vmask,
                              input logic [2:0] rmask, input int n_commit);
        logic [`RN_XLEN-1:0] w [`RN_LANES];
        w = '{w0, w1, w2};
        @(negedge clk);
        for (int l = 0; l < `RN_LANES; l++) begin
            decode_valid[l]   = vmask[l];
            instr[l]          = w[l];
            pc_in[l]          = pc_next;
            pc_next           = pc_next + 4;
            dispatch_ready[l] = rmask[l];
            commit_valid[l]   = 1'b0;
            commit_tag[l]     = '0;
            if ((l < n_commit) && (retire_q.size() > 0)) begin
                commit_valid[l] = 1'b1;
                commit_tag[l]   = retire_q.pop_front();
            end
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            err_cnt++;
            $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // ====================
    // Compare at each rising edge
    // ====================
    always @(posedge clk) begin
        if (reset) begin
            // Registered outputs still show the previous edge here
            for (int l = 0; l < `RN_LANES; l++) begin
                check_value($sformatf("lane %0d valid", l), exp_valid[l], issue_valid[l]);
                check_value($sformatf("lane %0d pc", l), exp_pc[l], pc_out[l]);
                check_value($sformatf("lane %0d rs1", l), exp_rs1[l], rs1_phys[l]);
                check_value($sformatf("lane %0d rs2", l), exp_rs2[l], rs2_phys[l]);
                check_value($sformatf("lane %0d rd_phys", l), exp_rd_phys[l], rd_phys[l]);
                check_value($sformatf("lane %0d old_rd", l), exp_old[l], old_rd_phys[l]);
                check_value($sformatf("lane %0d rd_arch", l), exp_rd_arch[l], rd_arch[l]);
                check_value($sformatf("lane %0d rd_we", l), exp_we[l], rd_we[l]);
            end
            model_step();
            for (int l = 0; l < `RN_LANES; l++) begin
                check_value($sformatf("lane %0d ready", l), exp_ready[l], decode_ready[l]);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [2:0] stall_masks [6];
        stall_masks = '{3'b110, 3'b101, 3'b011, 3'b000, 3'b010, 3'b100};
        void'($urandom(10715));
        model_reset();
        drive_idle();
        reset = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b1;

        test_name = "reset_group";
        step_group(enc(OP, 1, 2, 3), enc(OP, 4, 5, 6), enc(OP_IMM, 5, 7, 0), 3'b111, 3'b111, 0);
        test_name = "intra_group";
        step_group(enc(OP, 6, 1, 2), enc(OP, 7, 6, 6), enc(OP_IMM, 6, 7, 0), 3'b111, 3'b111, 0);
        test_name = "non_writing";
        step_group(enc(STORE, 9, 3, 4), enc(BRANCH, 11, 6, 7), enc(OP, 0, 6, 7),
                   3'b111, 3'b111, 0);
        step_group(enc(LUI, 8, 3, 4), enc(AUIPC, 9, 5, 6), enc(JAL, 10, 7, 1),
                   3'b111, 3'b111, 0);
        test_name = "exhaust";
        repeat (7) step_group(rand_writer(), rand_writer(), rand_writer(), 3'b111, 3'b111, 0);
        // Lane 1 stalled while the last two tags go out
        step_group(rand_writer(), rand_writer(), rand_writer(), 3'b111, 3'b101, 0);
        repeat (4) step_group(rand_writer(), rand_writer(), rand_writer(), 3'b111, 3'b111, 0);
        test_name = "recycle";
        repeat (10) step_group(rand_writer(), rand_writer(), rand_writer(), 3'b111, 3'b111, 3);
        test_name = "back_pressure";
        for (int k = 0; k < 6; k++) begin
            step_group(rand_instr(), rand_instr(), rand_instr(), 3'b111, stall_masks[k], 1);
        end
        test_name = "random";
        repeat (RANDOM_GROUPS) step_group(rand_instr(), rand_instr(), rand_instr(),
                                          3'($urandom()), 3'($urandom()),
                                          $urandom_range(3));
        test_name = "drain";
        repeat (4) step_group('0, '0, '0, 3'b000, 3'b111, 0);
        @(negedge clk);

        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
+incdir+sim
verilog/rename_pkg.sv
verilog/reg_field_decoder.sv
verilog/rename_map.sv
verilog/phys_reg_allocator.sv
verilog/issue_pipe_reg.sv
verilog/rename_stage.sv
sim/rename_tb.sv

// File: Bender.yml
package:
  name: rename_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/rename_pkg.sv
      - verilog/reg_field_decoder.sv
      - verilog/rename_map.sv
      - verilog/phys_reg_allocator.sv
      - verilog/issue_pipe_reg.sv
      - verilog/rename_stage.sv
  - target: simulation
    include_dirs:
      - include
      - sim
    files:
      - sim/rename_tb.sv
